// File: bench/core_stimulus.mem
// Words at @00 are the program, @20 holds program word count and store count,
// then expected store address and data per line, @3F holds the faulting address
@00
123450B7 // lui  x1, 0x12345
10000113 // addi x2, x0, 0x100
67808193 // addi x3, x1, 0x678
00312023 // sw   x3, 0(x2)
FFF00213 // addi x4, x0, -1
0041C2B3 // xor  x5, x3, x4
00512223 // sw   x5, 4(x2)
40118333 // sub  x6, x3, x1
0F000413 // addi x8, x0, 0xf0
0081F3B3 // and  x7, x3, x8
0070E4B3 // or   x9, x1, x7
00930533 // add  x10, x6, x9
00A12423 // sw   x10, 8(x2)
00712623 // sw   x7, 12(x2)
00012583 // lw   x11, 0(x2)
00B12823 // sw   x11, 16(x2) right after the load
00412603 // lw   x12, 4(x2)
00160693 // addi x13, x12, 1
00D12A23 // sw   x13, 20(x2)
00C12C23 // sw   x12, 24(x2)
F0000737 // lui  x14, 0xf0000
00372023 // sw   x3, 0(x14) answered with ERROR
@20
00000016 00000007
00000100 12345678
00000104 EDCBA987
00000108 123456E8
0000010C 00000070
00000110 12345678
00000114 EDCBA988
00000118 EDCBA987
@3F
F0000000

// File: bench/rv32_core_ahb_checker.sv
`timescale 1ns/10ps
`include "rv_core_cfg.svh"

module rv32_core_ahb_checker (
    input logic        i_clk,
    input logic        i_reset_n,
    input logic [1:0]  i_htrans,
    input logic [31:0] i_haddr,
    input logic        i_hwrite,
    input logic        i_hready
);

    int assert_errors = 0;  // Failed assertion count

    // No transfer may start while the core sits in reset
    htrans_idle_in_reset: assert property (
        @(posedge i_clk) !i_reset_n |-> (i_htrans == `HTRANS_IDLE)
    ) else begin
        assert_errors++;
        $error("HTRANS not idle while reset is active");
    end

    haddr_word_aligned: assert property (
        @(posedge i_clk) disable iff (!i_reset_n)
        (i_htrans == `HTRANS_NONSEQ) |-> (i_haddr[1:0] == 2'b00) // Word access only
    ) else begin
        assert_errors++;
        $error("HADDR not word aligned during NONSEQ");
    end

    // Slave wait states must not see address or direction move
    ctrl_stable_in_wait: assert property (
        @(posedge i_clk) disable iff (!i_reset_n)
        !i_hready |=> ($stable(i_haddr) && $stable(i_hwrite))
    ) else begin
        assert_errors++;
        $error("HADDR or HWRITE changed while HREADY was low");
    end

endmodule

bind rv32_core_ahb rv32_core_ahb_checker i_rv32_core_ahb_checker (
    .i_clk     (clk),
    .i_reset_n (reset_n),
    .i_htrans  (o_htrans),
    .i_haddr   (o_haddr),
    .i_hwrite  (o_hwrite),
    .i_hready  (i_hready)
);

// File: bench/tb_rv32_core_ahb.sv
`timescale 1ns/10ps
`include "rv_core_cfg.svh"

module tb_rv32_core_ahb;

    localparam int MEM_WORDS  = 256;  // 1 KiB slave memory
    localparam int MAX_WAIT   = 3;    // Wait states per data phase
    localparam int DRAIN_CYC  = 40;   // Bus watched this long after the fault
    localparam int COUNT_AT   = 32;   // Program and store counts in the data file
    localparam int PAIRS_AT   = 34;   // First expected store pair
    localparam int FAULT_AT   = 63;   // Faulting store address

    logic        clk;
    logic        reset_n;
    logic [31:0] haddr;
    logic [1:0]  htrans;
    logic        hwrite;
    logic [31:0] hwdata;
    logic [3:0]  hprot;
    logic [31:0] hrdata;
    logic        hready;
    logic        hresp;
    logic        fault;

    logic [31:0] stim [64];
    logic [31:0] mem [MEM_WORDS];
    logic [31:0] rng;
    logic [31:0] fault_addr;
    logic [31:0] next_fetch;  // Expected address of the next instruction read
    logic        first_xfer;
    logic        dp_active;   // Slave is in a data phase
    logic [31:0] dp_addr;
    logic        dp_write;
    logic        dp_error;    // Address outside memory
    logic        err_first;   // First ERROR cycle already driven
    logic        fault_due;
    logic        fault_seen;
    int          wait_left;
    int          prog_words;
    int          n_stores;
    int          store_idx;
    int          mismatches;
    int          failures;
    int          assert_fails;
    int          cycles;
    int          limit;
    int          drain;

    rv32_core_ahb i_rv32_core_ahb (
        .clk      (clk),
        .reset_n  (reset_n),
        .o_haddr  (haddr),
        .o_htrans (htrans),
        .o_hwrite (hwrite),
        .o_hwdata (hwdata),
        .o_hprot  (hprot),
        .i_hrdata (hrdata),
        .i_hready (hready),
        .i_hresp  (hresp),
        .o_fault  (fault)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic report_failure(input string what);
        failures++;
        $display("error: %s", what);
    endtask

    task automatic load_memory;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 32'hA5A5_0000 ^ i;   // Unused words carry their index
        end
        for (int i = 0; i < prog_words; i++) begin
            mem[i] = stim[i];
        end
    endtask

    // NONSEQ seen with HREADY high starts a data phase
    task automatic accept_address;
        rng       = lcg_next(rng);
        wait_left = int'(rng[23:16]) % (MAX_WAIT + 1);
        dp_active = 1'b1;
        dp_addr   = haddr;
        dp_write  = hwrite;
        dp_error  = (haddr >= 32'(MEM_WORDS * 4));
        err_first = 1'b0;
        if (first_xfer) begin
            check_value("o_haddr", haddr, `CORE_RESET_PC);
            check_value("o_hprot", hprot, `HPROT_OPCODE);
            first_xfer = 1'b0;
        end
        if (!hwrite && haddr < 32'(prog_words * 4)) begin  // Read from the program area
            check_value("o_hprot", hprot, `HPROT_OPCODE);
            check_value("o_haddr", haddr, next_fetch);
            next_fetch = next_fetch + 32'd4;
        end else begin
            check_value("o_hprot", hprot, `HPROT_DATA);
        end
        if (dp_error) begin
            check_value("o_haddr", haddr, fault_addr);
            check_value("o_hwrite", hwrite, 1'b1);
            if (store_idx != n_stores) begin
                report_failure("fault store came before all expected stores");
            end
        end
    endtask

    task automatic compare_store;
        if (store_idx >= n_stores) begin
            report_failure("store seen beyond the expected list");
        end else begin
            check_value("o_haddr", dp_addr, stim[PAIRS_AT + 2 * store_idx]);
            check_value("o_hwdata", hwdata, stim[PAIRS_AT + 2 * store_idx + 1]);
            store_idx++;
        end
    endtask

    task automatic run_data_phase;
        hrdata = 32'd0;
        if (wait_left > 0) begin
            hready = 1'b0;
            hresp  = 1'b0;
            wait_left--;
        end else if (dp_error && !err_first) begin
            hready    = 1'b0;   // Two-cycle ERROR response
            hresp     = 1'b1;
            err_first = 1'b1;
        end else if (dp_error) begin
            hready    = 1'b1;
            hresp     = 1'b1;
            dp_active = 1'b0;
            fault_due = 1'b1;
        end else begin
            hready    = 1'b1;
            hresp     = 1'b0;
            dp_active = 1'b0;
            if (dp_write) begin
                compare_store;
                mem[dp_addr[9:2]] = hwdata;
            end else begin
                hrdata = mem[dp_addr[9:2]];
            end
        end
    endtask

    // One slave cycle decided at the falling edge
    task automatic serve_bus_cycle;
        if (fault_due) begin
            check_value("o_fault", fault, 1'b1);  // One edge after ERROR
            fault_due  = 1'b0;
            fault_seen = 1'b1;
        end else begin
            check_value("o_fault", fault, fault_seen);
        end
        if (fault_seen) begin
            drain++;
            if (htrans != `HTRANS_IDLE) begin
                report_failure("bus transfer started after the fault");
            end
        end
        if (dp_active) begin
            run_data_phase;
        end else begin
            hready = 1'b1;
            hresp  = 1'b0;
            hrdata = 32'd0;
            if (htrans == `HTRANS_NONSEQ) begin
                accept_address;
            end
        end
    endtask

    initial begin
        reset_n      = 1'b0;
        hrdata       = 32'd0;
        hready       = 1'b1;
        hresp        = 1'b0;
        rng          = 32'h4124;
        mismatches   = 0;
        failures     = 0;
        assert_fails = 0;
        cycles       = 0;
        drain        = 0;
        store_idx    = 0;
        wait_left    = 0;
        dp_active    = 1'b0;
        dp_addr      = 32'd0;
        dp_write     = 1'b0;
        dp_error     = 1'b0;
        err_first    = 1'b0;
        fault_due    = 1'b0;
        fault_seen   = 1'b0;
        first_xfer   = 1'b1;
        next_fetch   = `CORE_RESET_PC;
        $readmemh("bench/core_stimulus.mem", stim);
        prog_words = stim[COUNT_AT];
        n_stores   = stim[COUNT_AT + 1];
        fault_addr = stim[FAULT_AT];
        // Every transfer costs at most idle, address and data plus waits
        limit = (prog_words + 2 * n_stores) * (MAX_WAIT + 4) + DRAIN_CYC + 100;
        load_memory;
        repeat (16) @(posedge clk);
        @(negedge clk);
        check_value("o_htrans", htrans, `HTRANS_IDLE);
        check_value("o_fault", fault, 1'b0);
        reset_n = 1'b1;
        while (drain < DRAIN_CYC && cycles < limit) begin
            @(negedge clk);
            cycles++;
            serve_bus_cycle;
        end
        if (drain < DRAIN_CYC) begin
            report_failure("timeout, the faulting store did not end the program in time");
        end
        if (store_idx != n_stores) begin
            report_failure("not all expected stores appeared on the bus");
        end
        assert_fails = i_rv32_core_ahb.i_rv32_core_ahb_checker.assert_errors;
        $display("%0d mismatches, %0d other errors, %0d assertion failures, %0d of %0d stores, %0d cycles",
                 mismatches, failures, assert_fails, store_idx, n_stores, cycles);
        if (mismatches == 0 && failures == 0 && assert_fails == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+hw
hw/rv_core_pkg.sv
hw/rv_fetch_unit.sv
hw/rv_exec_unit.sv
hw/ahb_master_arbiter.sv
hw/rv32_core_ahb.sv
bench/rv32_core_ahb_checker.sv
bench/tb_rv32_core_ahb.sv

// File: hw/ahb_master_arbiter.sv
`timescale 1ns/10ps
`include "rv_core_cfg.svh"

module ahb_master_arbiter (
    input  logic                  i_clk,
    input  logic                  i_reset_n,
    input  logic                  i_fetch_valid,
    input  rv_core_pkg::bus_req_t i_fetch_req,
    output rv_core_pkg::bus_rsp_t o_fetch_rsp,
    input  logic                  i_data_valid,
    input  rv_core_pkg::bus_req_t i_data_req,
    output rv_core_pkg::bus_rsp_t o_data_rsp,
    output logic [31:0]           o_haddr,
    output logic [1:0]            o_htrans,
    output logic                  o_hwrite,
    output logic [31:0]           o_hwdata,
    output logic [3:0]            o_hprot,
    input  logic [31:0]           i_hrdata,
    input  logic                  i_hready,
    input  logic                  i_hresp,
    output logic                  o_fault    // Sticky bus error
);
    import rv_core_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,  // NONSEQ on the bus
        ST_DATA   // Wait for HREADY
    } state_e;

    state_e   state;
    bus_req_t xfer;       // Request that owns the bus
    logic     owner_data; // Data side owns the transfer
    logic     fault_q;
    bus_rsp_t rsp;

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            state      <= ST_IDLE;
            xfer       <= '0;
            owner_data <= 1'b0;
            fault_q    <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (!fault_q && i_data_valid) begin         // Data wins ties
                        xfer       <= i_data_req;
                        owner_data <= 1'b1;
                        state      <= ST_ADDR;
                    end else if (!fault_q && i_fetch_valid) begin
                        xfer       <= i_fetch_req;
                        owner_data <= 1'b0;
                        state      <= ST_ADDR;
                    end
                end
                ST_ADDR: begin
                    if (i_hready) begin
                        state <= ST_DATA;   // Address accepted
                    end
                end
                ST_DATA: begin
                    if (i_hready) begin
                        state <= ST_IDLE;
                        if (i_hresp) begin
                            fault_q <= 1'b1; // No grants after this
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Reply goes only to the owner
    assign rsp.done  = (state == ST_DATA) && i_hready;
    assign rsp.error = rsp.done && i_hresp;
    assign rsp.rdata = i_hrdata;

    assign o_fetch_rsp = owner_data ? bus_rsp_t'('0) : rsp;
    assign o_data_rsp  = owner_data ? rsp : bus_rsp_t'('0);

    // Address and control stay put for the whole transfer
    assign o_haddr  = xfer.addr;
    assign o_hwrite = xfer.write;
    assign o_htrans = (state == ST_ADDR) ? `HTRANS_NONSEQ : `HTRANS_IDLE;
    assign o_hwdata = (state == ST_DATA) ? xfer.wdata : 32'd0;
    assign o_hprot  = owner_data ? `HPROT_DATA : `HPROT_OPCODE;
    assign o_fault  = fault_q;

endmodule

// File: hw/rv32_core_ahb.sv
`timescale 1ns/10ps

module rv32_core_ahb (
    input  logic        clk,
    input  logic        reset_n,
    output logic [31:0] o_haddr,
    output logic [1:0]  o_htrans,
    output logic        o_hwrite,
    output logic [31:0] o_hwdata,
    output logic [3:0]  o_hprot,
    input  logic [31:0] i_hrdata,
    input  logic        i_hready,
    input  logic        i_hresp,
    output logic        o_fault
);
    import rv_core_pkg::*;

    logic        fetch_req_valid;
    bus_req_t    fetch_req;
    bus_rsp_t    fetch_rsp;
    logic        instr_valid;     // Buffer to execute
    logic [31:0] instr;
    logic        instr_take;
    logic        data_req_valid;
    bus_req_t    data_req;
    bus_rsp_t    data_rsp;

    rv_fetch_unit i_rv_fetch_unit (
        .i_clk         (clk),
        .i_reset_n     (reset_n),
        .i_take        (instr_take),
        .i_halt        (o_fault),        // Fault freezes the PC
        .o_req_valid   (fetch_req_valid),
        .o_req         (fetch_req),
        .i_rsp         (fetch_rsp),
        .o_instr_valid (instr_valid),
        .o_instr       (instr)
    );

    rv_exec_unit i_rv_exec_unit (
        .i_clk         (clk),
        .i_reset_n     (reset_n),
        .i_instr_valid (instr_valid),
        .i_instr       (instr),
        .o_take        (instr_take),
        .o_req_valid   (data_req_valid),
        .o_req         (data_req),
        .i_rsp         (data_rsp)
    );

    ahb_master_arbiter i_ahb_master_arbiter (
        .i_clk         (clk),
        .i_reset_n     (reset_n),
        .i_fetch_valid (fetch_req_valid),
        .i_fetch_req   (fetch_req),
        .o_fetch_rsp   (fetch_rsp),
        .i_data_valid  (data_req_valid),
        .i_data_req    (data_req),
        .o_data_rsp    (data_rsp),
        .o_haddr       (o_haddr),
        .o_htrans      (o_htrans),
        .o_hwrite      (o_hwrite),
        .o_hwdata      (o_hwdata),
        .o_hprot       (o_hprot),
        .i_hrdata      (i_hrdata),
        .i_hready      (i_hready),
        .i_hresp       (i_hresp),
        .o_fault       (o_fault)
    );

endmodule

// File: hw/rv_core_cfg.svh
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

// First fetch address out of reset
`define CORE_RESET_PC 32'h0000_0000

// HPROT bit 0 marks a data access, bit 1 privileged mode
`define HPROT_OPCODE 4'b0010
`define HPROT_DATA   4'b0011

// Transfer types used by a single-transfer master
`define HTRANS_IDLE   2'b00
`define HTRANS_NONSEQ 2'b10

// Byte step between consecutive instructions
`define CORE_PC_STEP 32'd4

`endif

// File: hw/rv_core_pkg.sv
package rv_core_pkg;

    // RV32I major opcodes handled by the core
    localparam logic [6:0] OPC_OP    = 7'b0110011; // Register ALU ops
    localparam logic [6:0] OPC_IMM   = 7'b0010011; // Immediate ALU ops
    localparam logic [6:0] OPC_LUI   = 7'b0110111;
    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;

    localparam logic [2:0] F3_ADD  = 3'b000; // ADD, SUB, ADDI
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;
    localparam logic [2:0] F3_WORD = 3'b010; // LW and SW width

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    // Request from one bus client to the arbiter
    typedef struct packed {
        logic [31:0] addr;  // Word address
        logic        write; // Store when set
        logic [31:0] wdata; // Store data
    } bus_req_t;

    // Reply from the arbiter to the owning client
    typedef struct packed {
        logic        done;  // Data phase finished
        logic        error; // HRESP error seen
        logic [31:0] rdata; // HRDATA at done
    } bus_rsp_t;

    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_XOR    = 3'd4,
        ALU_PASS_B = 3'd5  // LUI passes the immediate
    } alu_op_e;

    typedef struct packed {
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] imm;       // Sign-extended or upper immediate
        alu_op_e     alu_op;
        logic        use_imm;   // ALU B from imm
        logic        reg_write; // Writes rd at retire
        logic        load;
        logic        store;
    } decoded_t;

endpackage

// File: hw/rv_exec_unit.sv
`timescale 1ns/10ps

module rv_exec_unit (
    input  logic                  i_clk,
    input  logic                  i_reset_n,
    input  logic                  i_instr_valid,
    input  logic [31:0]           i_instr,
    output logic                  o_take,      // Retire pulse to fetch
    output logic                  o_req_valid, // Load or store request
    output rv_core_pkg::bus_req_t o_req,
    input  rv_core_pkg::bus_rsp_t i_rsp
);
    import rv_core_pkg::*;

    decoded_t    dec;
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] regs [32];  // Entry 0 never written
    logic [31:0] rs1_val;
    logic [31:0] rs2_val;
    logic [31:0] alu_b;
    logic [31:0] alu_res;
    logic        mem_op;
    logic        load_wb;    // Load data captured, retire now
    logic [31:0] load_data;
    logic [31:0] wb_data;
    logic        rd_we;

    assign opcode = i_instr[6:0];
    assign funct3 = i_instr[14:12];
    assign funct7 = i_instr[31:25];

    // Unsupported encodings decode to a no-op
    always_comb begin
        dec     = '0;
        dec.rd  = i_instr[11:7];
        dec.rs1 = i_instr[19:15];
        dec.rs2 = i_instr[24:20];
        dec.imm = {{20{i_instr[31]}}, i_instr[31:20]}; // I-type default
        case (opcode)
            OPC_OP: begin
                if (funct7 == F7_BASE) begin
                    dec.reg_write = 1'b1;
                    case (funct3)
                        F3_ADD:  dec.alu_op = ALU_ADD;
                        F3_XOR:  dec.alu_op = ALU_XOR;
                        F3_OR:   dec.alu_op = ALU_OR;
                        F3_AND:  dec.alu_op = ALU_AND;
                        default: dec.reg_write = 1'b0; // Shifts and compares
                    endcase
                end else if (funct7 == F7_SUB && funct3 == F3_ADD) begin
                    dec.alu_op    = ALU_SUB;
                    dec.reg_write = 1'b1;
                end
            end
            OPC_IMM: begin
                if (funct3 == F3_ADD) begin // ADDI only
                    dec.use_imm   = 1'b1;
                    dec.reg_write = 1'b1;
                end
            end
            OPC_LUI: begin
                dec.imm       = {i_instr[31:12], 12'd0};
                dec.alu_op    = ALU_PASS_B;
                dec.use_imm   = 1'b1;
                dec.reg_write = 1'b1;
            end
            OPC_LOAD: begin
                if (funct3 == F3_WORD) begin
                    dec.use_imm   = 1'b1;   // Address is rs1 + imm
                    dec.reg_write = 1'b1;
                    dec.load      = 1'b1;
                end
            end
            OPC_STORE: begin
                if (funct3 == F3_WORD) begin
                    dec.imm     = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
                    dec.use_imm = 1'b1;
                    dec.store   = 1'b1;
                end
            end
            default: dec.reg_write = 1'b0;
        endcase
    end

    // Register read with x0 forced to zero
    assign rs1_val = (dec.rs1 == 5'd0) ? 32'd0 : regs[dec.rs1];
    assign rs2_val = (dec.rs2 == 5'd0) ? 32'd0 : regs[dec.rs2];
    assign alu_b   = dec.use_imm ? dec.imm : rs2_val;

    always_comb begin
        case (dec.alu_op)
            ALU_ADD:    alu_res = rs1_val + alu_b;
            ALU_SUB:    alu_res = rs1_val - alu_b;
            ALU_AND:    alu_res = rs1_val & alu_b;
            ALU_OR:     alu_res = rs1_val | alu_b;
            ALU_XOR:    alu_res = rs1_val ^ alu_b;
            ALU_PASS_B: alu_res = alu_b;
            default:    alu_res = 32'd0;
        endcase
    end

    assign mem_op = dec.load || dec.store;

    // Request held until done, dropped during the load write-back cycle
    assign o_req_valid = i_instr_valid && mem_op && !load_wb;
    assign o_req       = '{addr: alu_res, write: dec.store, wdata: rs2_val};

    assign o_take = i_instr_valid && (!mem_op
                                      || (dec.store && i_rsp.done)
                                      || (dec.load && load_wb));

    assign wb_data = dec.load ? load_data : alu_res;
    assign rd_we   = o_take && dec.reg_write && (dec.rd != 5'd0);

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            load_wb <= 1'b0;
        end else begin
            if (load_wb) begin
                load_wb <= 1'b0;
            end else if (i_instr_valid && dec.load && i_rsp.done) begin
                load_wb <= 1'b1;    // Retire one cycle after done
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (rd_we) begin
            regs[dec.rd] <= wb_data;
        end
        if (dec.load && i_rsp.done) begin
            load_data <= i_rsp.rdata;
        end
    end

endmodule

// File: hw/rv_fetch_unit.sv
`timescale 1ns/10ps
`include "rv_core_cfg.svh"

module rv_fetch_unit (
    input  logic                  i_clk,
    input  logic                  i_reset_n,
    input  logic                  i_take,        // Execute retires buffered word
    input  logic                  i_halt,        // Fault stops new fetches
    output logic                  o_req_valid,
    output rv_core_pkg::bus_req_t o_req,
    input  rv_core_pkg::bus_rsp_t i_rsp,
    output logic                  o_instr_valid,
    output logic [31:0]           o_instr
);

    logic [31:0] pc;        // Address of the next request
    logic [31:0] req_addr;  // Address of the request in flight
    logic        req_pend;  // Request issued, done not yet seen
    logic        buf_valid; // Prefetch buffer holds a word
    logic [31:0] buf_word;
    logic        issue;     // New request this cycle
    logic        fill;      // Good read data returns

    // Only one fetch outstanding, buffer is free by the time it returns
    assign issue = !req_pend && (!buf_valid || i_take) && !i_halt;
    assign fill  = i_rsp.done && !i_rsp.error;

    // Level held from issue until done
    assign o_req_valid = issue || req_pend;
    assign o_req       = '{addr:  (req_pend ? req_addr : pc),
                           write: 1'b0,
                           wdata: 32'd0};

    assign o_instr_valid = buf_valid;
    assign o_instr       = buf_word;

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            pc       <= `CORE_RESET_PC;
            req_pend <= 1'b0;
        end else begin
            if (issue) begin
                req_pend <= 1'b1;
                pc       <= pc + `CORE_PC_STEP; // Step on each issued request
            end else if (i_rsp.done) begin
                req_pend <= 1'b0;               // Error also ends the request
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            buf_valid <= 1'b0;
        end else begin
            if (fill) begin
                buf_valid <= 1'b1;
            end else if (i_take) begin
                buf_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (issue) begin
            req_addr <= pc;         // Hold address while arbiter is busy
        end
        if (fill) begin
            buf_word <= i_rsp.rdata;
        end
    end

endmodule
